/* rtl/lb_cfg_pkg.sv */
// sizing constants; REQ_DEPTH must equal 2**SEQ_W so that sequence tags never alias
package lb_cfg_pkg;

    // requester ports and memory channels
    localparam int NUM_PORTS = 4;
    localparam int NUM_CH = 4;

    // payload widths
    localparam int ADDR_W = 48;
    localparam int DATA_W = 64;
    localparam int SEQ_W = 3;
    localparam int PORT_W = 2;

    // queue depths, REQ_DEPTH doubles as per-port credit
    localparam int REQ_DEPTH = 8;
    localparam int TAG_DEPTH = 8;
    localparam int POST_DEPTH = 4;

    // served counters wrap after 2**SERVE_W dispatches
    localparam int SERVE_W = 32;

endpackage

/* rtl/lb_types_pkg.sv */
// payload structs; field widths follow lb_cfg_pkg, which must be compiled first
package lb_types_pkg;

    // one queued read as it sits in a port queue
    typedef struct packed {
        logic [lb_cfg_pkg::ADDR_W-1:0] addr;
        logic [lb_cfg_pkg::SEQ_W-1:0]  seq;
    } req_t;

    // identifies the owner of an in-flight read
    typedef struct packed {
        logic [lb_cfg_pkg::PORT_W-1:0] port;
        logic [lb_cfg_pkg::SEQ_W-1:0]  seq;
    } tag_t;

    // returned beat paired with its tag
    typedef struct packed {
        tag_t                          tag;
        logic [lb_cfg_pkg::DATA_W-1:0] data;
    } resp_t;

endpackage

/* rtl/tag_fifo.sv */
// DEPTH must be a power of two; a write while full or a read while empty is ignored
module tag_fifo #(
    parameter type T = logic [7:0],
    parameter int DEPTH = 8
) (
    input  logic clk,
    input  logic rstn,
    input  logic wr_en,
    input  T     wr_data,
    input  logic rd_en,
    output T     rd_data,
    output logic empty,
    output logic full
);

    T mem [DEPTH];

    // one extra msb tells full from empty
    logic [$clog2(DEPTH):0] wr_ptr;
    logic [$clog2(DEPTH):0] rd_ptr;
    logic do_wr;
    logic do_rd;

    assign empty = (wr_ptr == rd_ptr);
    assign full = (wr_ptr[$clog2(DEPTH)] != rd_ptr[$clog2(DEPTH)]) &&
                  (wr_ptr[$clog2(DEPTH)-1:0] == rd_ptr[$clog2(DEPTH)-1:0]);
    assign do_wr = wr_en & ~full;
    assign do_rd = rd_en & ~empty;

    // show-ahead head
    assign rd_data = mem[rd_ptr[$clog2(DEPTH)-1:0]];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr[$clog2(DEPTH)-1:0]] <= wr_data;
        end
    end

endmodule

/* rtl/req_intake.sv */
// credit of REQ_DEPTH reads per port; ret_fire must pulse once for every accepted read
module req_intake (
    input  logic                                                  clk,
    input  logic                                                  rstn,
    input  logic [lb_cfg_pkg::NUM_PORTS-1:0]                      s_ar_valid,
    input  logic [lb_cfg_pkg::NUM_PORTS-1:0][lb_cfg_pkg::ADDR_W-1:0] s_ar_addr,
    output logic [lb_cfg_pkg::NUM_PORTS-1:0]                      s_ar_ready,
    input  logic [lb_cfg_pkg::NUM_PORTS-1:0]                      pop,
    input  logic [lb_cfg_pkg::NUM_PORTS-1:0]                      ret_fire,
    output logic [lb_cfg_pkg::NUM_PORTS-1:0]                      head_valid,
    output lb_types_pkg::req_t [lb_cfg_pkg::NUM_PORTS-1:0]        head
);

    for (genvar p = 0; p < lb_cfg_pkg::NUM_PORTS; p++) begin : g_port
        // reads accepted but not yet returned to the requester
        logic [$clog2(lb_cfg_pkg::REQ_DEPTH):0] outstanding;
        logic [lb_cfg_pkg::SEQ_W-1:0]           seq;
        logic                                   accept;
        logic                                   empty;
        lb_types_pkg::req_t                     entry;

        assign s_ar_ready[p] = (outstanding < lb_cfg_pkg::REQ_DEPTH);
        assign accept = s_ar_valid[p] & s_ar_ready[p];
        assign entry = '{addr: s_ar_addr[p], seq: seq};
        assign head_valid[p] = ~empty;

        always_ff @(posedge clk) begin
            if (!rstn) begin
                outstanding <= '0;
                seq <= '0;
            end else begin
                if (accept && !ret_fire[p]) begin
                    outstanding <= outstanding + 1'b1;
                end else if (!accept && ret_fire[p]) begin
                    outstanding <= outstanding - 1'b1;
                end
                // tag wraps, credit keeps live tags unique
                if (accept) begin
                    seq <= seq + 1'b1;
                end
            end
        end

        // queue never overflows since its depth equals the credit
        tag_fifo #(
            .T     (lb_types_pkg::req_t),
            .DEPTH (lb_cfg_pkg::REQ_DEPTH)
        ) u_req_fifo (
            .clk     (clk),
            .rstn    (rstn),
            .wr_en   (accept),
            .wr_data (entry),
            .rd_en   (pop[p]),
            .rd_data (head[p]),
            .empty   (empty),
            .full    ()
        );
    end

endmodule

/* rtl/dispatch_arbiter.sv */
// one dispatch per cycle; m_ar_valid depends combinationally on m_ar_ready
module dispatch_arbiter (
    input  logic                                               clk,
    input  logic                                               rstn,
    input  logic [lb_cfg_pkg::NUM_PORTS-1:0]                   head_valid,
    input  lb_types_pkg::req_t [lb_cfg_pkg::NUM_PORTS-1:0]     head,
    output logic [lb_cfg_pkg::NUM_PORTS-1:0]                   pop,
    input  logic [lb_cfg_pkg::NUM_CH-1:0]                      ch_idle,
    input  logic [lb_cfg_pkg::NUM_CH-1:0]                      ch_can_take,
    input  logic [lb_cfg_pkg::NUM_CH-1:0]                      m_ar_ready,
    output logic [lb_cfg_pkg::NUM_CH-1:0]                      m_ar_valid,
    output logic [lb_cfg_pkg::NUM_CH-1:0][lb_cfg_pkg::ADDR_W-1:0] m_ar_addr,
    output logic [lb_cfg_pkg::NUM_CH-1:0]                      issue,
    output lb_types_pkg::tag_t                                 issue_tag
);

    // dispatches granted to each port so far
    logic [lb_cfg_pkg::NUM_PORTS-1:0][lb_cfg_pkg::SERVE_W-1:0] served;
    logic [lb_cfg_pkg::SERVE_W-1:0] best_cnt;
    logic [lb_cfg_pkg::PORT_W-1:0]  sel_port;
    logic                           port_found;
    logic [lb_cfg_pkg::NUM_CH-1:0]  ch_sel;
    logic                           ch_found;
    logic                           fire;

    // least served nonempty port, strict compare keeps the lowest index on ties
    always_comb begin
        port_found = 1'b0;
        sel_port = '0;
        best_cnt = '0;
        for (int p = 0; p < lb_cfg_pkg::NUM_PORTS; p++) begin
            if (head_valid[p] && (!port_found || served[p] < best_cnt)) begin
                port_found = 1'b1;
                sel_port = p[lb_cfg_pkg::PORT_W-1:0];
                best_cnt = served[p];
            end
        end
    end

    // idle and ready first, then any ready channel with tag room
    always_comb begin
        ch_found = 1'b0;
        ch_sel = '0;
        for (int c = 0; c < lb_cfg_pkg::NUM_CH; c++) begin
            if (!ch_found && ch_idle[c] && m_ar_ready[c]) begin
                ch_found = 1'b1;
                ch_sel[c] = 1'b1;
            end
        end
        for (int c = 0; c < lb_cfg_pkg::NUM_CH; c++) begin
            if (!ch_found && ch_can_take[c] && m_ar_ready[c]) begin
                ch_found = 1'b1;
                ch_sel[c] = 1'b1;
            end
        end
    end

    assign fire = port_found & ch_found;
    assign m_ar_valid = fire ? ch_sel : '0;
    assign issue = m_ar_valid;
    assign issue_tag = '{port: sel_port, seq: head[sel_port].seq};

    always_comb begin
        pop = '0;
        pop[sel_port] = fire;
    end

    // address broadcast, only the selected channel sees valid
    for (genvar c = 0; c < lb_cfg_pkg::NUM_CH; c++) begin : g_addr
        assign m_ar_addr[c] = head[sel_port].addr;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            served <= '0;
        end else if (fire) begin
            served[sel_port] <= served[sel_port] + 1'b1;
        end
    end

endmodule

/* rtl/mem_channel.sv */
// memory must return reads in issue order and only for reads it has accepted
module mem_channel (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          issue,
    input  lb_types_pkg::tag_t            issue_tag,
    input  logic                          m_r_valid,
    input  logic [lb_cfg_pkg::DATA_W-1:0] m_r_data,
    output logic                          m_r_ready,
    output logic                          idle,
    output logic                          can_take,
    output logic                          post_valid,
    output lb_types_pkg::resp_t           post,
    output logic                          post_full,
    input  logic                          post_pop
);

    lb_types_pkg::tag_t  tag_head;
    lb_types_pkg::resp_t staged;
    logic                tag_empty;
    logic                tag_full;
    logic                post_empty;
    logic                beat;

    assign m_r_ready = ~post_full;
    assign beat = m_r_valid & m_r_ready;
    assign staged = '{tag: tag_head, data: m_r_data};
    assign idle = tag_empty & post_empty;
    assign can_take = ~tag_full;
    assign post_valid = ~post_empty;

    // tags of reads in flight, oldest at the head
    tag_fifo #(
        .T     (lb_types_pkg::tag_t),
        .DEPTH (lb_cfg_pkg::TAG_DEPTH)
    ) u_tag_fifo (
        .clk     (clk),
        .rstn    (rstn),
        .wr_en   (issue),
        .wr_data (issue_tag),
        .rd_en   (beat),
        .rd_data (tag_head),
        .empty   (tag_empty),
        .full    (tag_full)
    );

    // returned beats waiting for the reorder stage
    tag_fifo #(
        .T     (lb_types_pkg::resp_t),
        .DEPTH (lb_cfg_pkg::POST_DEPTH)
    ) u_post_fifo (
        .clk     (clk),
        .rstn    (rstn),
        .wr_en   (beat),
        .wr_data (staged),
        .rd_en   (post_pop),
        .rd_data (post),
        .empty   (post_empty),
        .full    (post_full)
    );

endmodule

/* rtl/reorder_return.sv */
// one staged response per cycle; relies on port credit so a slot is never refilled early
module reorder_return (
    input  logic                                                  clk,
    input  logic                                                  rstn,
    input  logic [lb_cfg_pkg::NUM_CH-1:0]                         post_valid,
    input  lb_types_pkg::resp_t [lb_cfg_pkg::NUM_CH-1:0]          post,
    input  logic [lb_cfg_pkg::NUM_CH-1:0]                         post_full,
    output logic [lb_cfg_pkg::NUM_CH-1:0]                         post_pop,
    output logic [lb_cfg_pkg::NUM_PORTS-1:0]                      s_r_valid,
    output logic [lb_cfg_pkg::NUM_PORTS-1:0][lb_cfg_pkg::DATA_W-1:0] s_r_data,
    input  logic [lb_cfg_pkg::NUM_PORTS-1:0]                      s_r_ready,
    output logic [lb_cfg_pkg::NUM_PORTS-1:0]                      ret_fire
);

    logic [lb_cfg_pkg::DATA_W-1:0] slot_data [lb_cfg_pkg::NUM_PORTS][lb_cfg_pkg::REQ_DEPTH];
    logic [lb_cfg_pkg::NUM_PORTS-1:0][lb_cfg_pkg::REQ_DEPTH-1:0] filled;
    logic [lb_cfg_pkg::NUM_PORTS-1:0][lb_cfg_pkg::SEQ_W-1:0] rptr;
    logic [lb_cfg_pkg::NUM_PORTS-1:0][lb_cfg_pkg::SEQ_W-1:0] nxt_ptr;
    lb_types_pkg::resp_t pick;
    lb_types_pkg::resp_t wr_resp;
    logic                pick_found;
    logic                wr_valid;

    // a full staging queue wins, then the lowest nonempty channel
    always_comb begin
        pick_found = 1'b0;
        pick = '0;
        post_pop = '0;
        for (int c = 0; c < lb_cfg_pkg::NUM_CH; c++) begin
            if (!pick_found && post_full[c]) begin
                pick_found = 1'b1;
                pick = post[c];
                post_pop[c] = 1'b1;
            end
        end
        for (int c = 0; c < lb_cfg_pkg::NUM_CH; c++) begin
            if (!pick_found && post_valid[c]) begin
                pick_found = 1'b1;
                pick = post[c];
                post_pop[c] = 1'b1;
            end
        end
    end

    for (genvar p = 0; p < lb_cfg_pkg::NUM_PORTS; p++) begin : g_ptr
        assign nxt_ptr[p] = rptr[p] + 1'b1;
        assign ret_fire[p] = s_r_valid[p] & s_r_ready[p];
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_valid <= 1'b0;
            filled <= '0;
            rptr <= '0;
            s_r_valid <= '0;
        end else begin
            wr_valid <= pick_found;
            for (int p = 0; p < lb_cfg_pkg::NUM_PORTS; p++) begin
                if (ret_fire[p]) begin
                    filled[p][rptr[p]] <= 1'b0;
                    rptr[p] <= nxt_ptr[p];
                    // back to back return when the next slot is already in
                    s_r_valid[p] <= filled[p][nxt_ptr[p]];
                end else if (!s_r_valid[p]) begin
                    s_r_valid[p] <= filled[p][rptr[p]];
                end
            end
            if (wr_valid) begin
                filled[wr_resp.tag.port][wr_resp.tag.seq] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pick_found) begin
            wr_resp <= pick;
        end
        if (wr_valid) begin
            slot_data[wr_resp.tag.port][wr_resp.tag.seq] <= wr_resp.data;
        end
        // data held while valid and not taken
        for (int p = 0; p < lb_cfg_pkg::NUM_PORTS; p++) begin
            if (ret_fire[p]) begin
                s_r_data[p] <= slot_data[p][nxt_ptr[p]];
            end else if (!s_r_valid[p]) begin
                s_r_data[p] <= slot_data[p][rptr[p]];
            end
        end
    end

endmodule

/* rtl/load_balancer.sv */
// single-beat reads only; each memory channel must answer in the order it accepted
module load_balancer (
    input  logic                                                  clk,
    input  logic                                                  rstn,
    input  logic [lb_cfg_pkg::NUM_PORTS-1:0]                      s_ar_valid,
    input  logic [lb_cfg_pkg::NUM_PORTS-1:0][lb_cfg_pkg::ADDR_W-1:0] s_ar_addr,
    output logic [lb_cfg_pkg::NUM_PORTS-1:0]                      s_ar_ready,
    output logic [lb_cfg_pkg::NUM_PORTS-1:0]                      s_r_valid,
    output logic [lb_cfg_pkg::NUM_PORTS-1:0][lb_cfg_pkg::DATA_W-1:0] s_r_data,
    input  logic [lb_cfg_pkg::NUM_PORTS-1:0]                      s_r_ready,
    output logic [lb_cfg_pkg::NUM_CH-1:0]                         m_ar_valid,
    output logic [lb_cfg_pkg::NUM_CH-1:0][lb_cfg_pkg::ADDR_W-1:0] m_ar_addr,
    input  logic [lb_cfg_pkg::NUM_CH-1:0]                         m_ar_ready,
    input  logic [lb_cfg_pkg::NUM_CH-1:0]                         m_r_valid,
    input  logic [lb_cfg_pkg::NUM_CH-1:0][lb_cfg_pkg::DATA_W-1:0] m_r_data,
    output logic [lb_cfg_pkg::NUM_CH-1:0]                         m_r_ready
);

    logic [lb_cfg_pkg::NUM_PORTS-1:0]                  head_valid;
    lb_types_pkg::req_t [lb_cfg_pkg::NUM_PORTS-1:0]    head;
    logic [lb_cfg_pkg::NUM_PORTS-1:0]                  pop;
    logic [lb_cfg_pkg::NUM_PORTS-1:0]                  ret_fire;
    logic [lb_cfg_pkg::NUM_CH-1:0]                     ch_idle;
    logic [lb_cfg_pkg::NUM_CH-1:0]                     ch_can_take;
    logic [lb_cfg_pkg::NUM_CH-1:0]                     issue;
    lb_types_pkg::tag_t                                issue_tag;
    logic [lb_cfg_pkg::NUM_CH-1:0]                     post_valid;
    lb_types_pkg::resp_t [lb_cfg_pkg::NUM_CH-1:0]      post;
    logic [lb_cfg_pkg::NUM_CH-1:0]                     post_full;
    logic [lb_cfg_pkg::NUM_CH-1:0]                     post_pop;

    // input side
    req_intake u_req_intake (
        .clk        (clk),
        .rstn       (rstn),
        .s_ar_valid (s_ar_valid),
        .s_ar_addr  (s_ar_addr),
        .s_ar_ready (s_ar_ready),
        .pop        (pop),
        .ret_fire   (ret_fire),
        .head_valid (head_valid),
        .head       (head)
    );

    // processing part
    dispatch_arbiter u_dispatch_arbiter (
        .clk         (clk),
        .rstn        (rstn),
        .head_valid  (head_valid),
        .head        (head),
        .pop         (pop),
        .ch_idle     (ch_idle),
        .ch_can_take (ch_can_take),
        .m_ar_ready  (m_ar_ready),
        .m_ar_valid  (m_ar_valid),
        .m_ar_addr   (m_ar_addr),
        .issue       (issue),
        .issue_tag   (issue_tag)
    );

    for (genvar c = 0; c < lb_cfg_pkg::NUM_CH; c++) begin : g_ch
        mem_channel u_mem_channel (
            .clk        (clk),
            .rstn       (rstn),
            .issue      (issue[c]),
            .issue_tag  (issue_tag),
            .m_r_valid  (m_r_valid[c]),
            .m_r_data   (m_r_data[c]),
            .m_r_ready  (m_r_ready[c]),
            .idle       (ch_idle[c]),
            .can_take   (ch_can_take[c]),
            .post_valid (post_valid[c]),
            .post       (post[c]),
            .post_full  (post_full[c]),
            .post_pop   (post_pop[c])
        );
    end

    // output side
    reorder_return u_reorder_return (
        .clk        (clk),
        .rstn       (rstn),
        .post_valid (post_valid),
        .post       (post),
        .post_full  (post_full),
        .post_pop   (post_pop),
        .s_r_valid  (s_r_valid),
        .s_r_data   (s_r_data),
        .s_r_ready  (s_r_ready),
        .ret_fire   (ret_fire)
    );

endmodule

/* verif/tb_mem_responder.sv */
// in-order read memory; accept_en and lat come from the testbench and are taken at the clock edge
module tb_mem_responder (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          accept_en,
    input  logic [2:0]                    lat,
    input  logic                          m_ar_valid,
    input  logic [lb_cfg_pkg::ADDR_W-1:0] m_ar_addr,
    output logic                          m_ar_ready,
    output logic                          m_r_valid,
    output logic [lb_cfg_pkg::DATA_W-1:0] m_r_data,
    input  logic                          m_r_ready
);

    logic [lb_cfg_pkg::DATA_W-1:0] data_q [$];
    int                            due_q [$];
    int                            cycle;
    logic [lb_cfg_pkg::DATA_W-1:0] word;

    initial begin
        m_ar_ready = 1'b0;
        m_r_valid = 1'b0;
        m_r_data = '0;
        cycle = 0;
    end

    always @(posedge clk) begin
        if (!rstn) begin
            data_q.delete();
            due_q.delete();
            m_ar_ready <= 1'b0;
            m_r_valid <= 1'b0;
        end else begin
            cycle = cycle + 1;
            if (m_r_valid && m_r_ready) begin
                void'(data_q.pop_front());
                void'(due_q.pop_front());
            end
            if (m_ar_valid && m_ar_ready) begin
                word = '0;
                word[lb_cfg_pkg::ADDR_W-1:0] = m_ar_addr;
                data_q.push_back(word ^ 64'hA5A5_0000_0000_0000);
                // latency of 1 to 8 cycles
                due_q.push_back(cycle + int'(lat) + 1);
            end
            if (due_q.size() != 0 && due_q[0] <= cycle) begin
                m_r_valid <= 1'b1;
                m_r_data <= data_q[0];
            end else begin
                m_r_valid <= 1'b0;
            end
            m_ar_ready <= accept_en;
        end
    end

endmodule

/* verif/tb_load_balancer.sv */
// rows sharing no port run together as one group; random bits from a 16-bit LFSR seeded with 61
module tb_load_balancer;

    typedef struct packed {
        logic [lb_cfg_pkg::PORT_W-1:0] port;
        logic [lb_cfg_pkg::ADDR_W-1:0] base;
        logic [7:0]                    count;
        logic                          stall;
    } stim_row_t;
    typedef logic [lb_cfg_pkg::ADDR_W-lb_cfg_pkg::PORT_W-1:0] addr_low_t;

    // a row whose port is already loaded starts the next group
    stim_row_t stim [8] = '{
        '{2'd0, 48'h0000_0010_0000, 8'd12, 1'b0},
        '{2'd1, 48'h0000_0020_0000, 8'd12, 1'b0},
        '{2'd2, 48'h0000_0030_0000, 8'd12, 1'b0},
        '{2'd3, 48'h0000_0040_0000, 8'd12, 1'b0},
        '{2'd1, 48'h0000_0520_0000, 8'd12, 1'b1},
        '{2'd0, 48'h0000_0510_0000, 8'd6,  1'b0},
        '{2'd2, 48'h0000_0530_0000, 8'd6,  1'b0},
        '{2'd3, 48'h0000_0540_0000, 8'd6,  1'b0}
    };

    logic clk;
    logic rstn;
    logic [lb_cfg_pkg::NUM_PORTS-1:0]                         s_ar_valid;
    logic [lb_cfg_pkg::NUM_PORTS-1:0][lb_cfg_pkg::ADDR_W-1:0] s_ar_addr;
    logic [lb_cfg_pkg::NUM_PORTS-1:0]                         s_ar_ready;
    logic [lb_cfg_pkg::NUM_PORTS-1:0]                         s_r_valid;
    logic [lb_cfg_pkg::NUM_PORTS-1:0][lb_cfg_pkg::DATA_W-1:0] s_r_data;
    logic [lb_cfg_pkg::NUM_PORTS-1:0]                         s_r_ready;
    logic [lb_cfg_pkg::NUM_CH-1:0]                            m_ar_valid;
    logic [lb_cfg_pkg::NUM_CH-1:0][lb_cfg_pkg::ADDR_W-1:0]    m_ar_addr;
    logic [lb_cfg_pkg::NUM_CH-1:0]                            m_ar_ready;
    logic [lb_cfg_pkg::NUM_CH-1:0]                            m_r_valid;
    logic [lb_cfg_pkg::NUM_CH-1:0][lb_cfg_pkg::DATA_W-1:0]    m_r_data;
    logic [lb_cfg_pkg::NUM_CH-1:0]                            m_r_ready;
    logic [lb_cfg_pkg::NUM_CH-1:0]                            mem_accept;
    logic [lb_cfg_pkg::NUM_CH-1:0][2:0]                       mem_lat;

    // reference model state per port
    logic [lb_cfg_pkg::DATA_W-1:0] exp_q [lb_cfg_pkg::NUM_PORTS][$];
    logic [lb_cfg_pkg::ADDR_W-1:0] addr_q [lb_cfg_pkg::NUM_PORTS][$];
    int sent [lb_cfg_pkg::NUM_PORTS];
    int row_count [lb_cfg_pkg::NUM_PORTS];
    int outstanding [lb_cfg_pkg::NUM_PORTS];
    logic [lb_cfg_pkg::NUM_PORTS-1:0][lb_cfg_pkg::ADDR_W-1:0] row_base;
    logic [lb_cfg_pkg::NUM_PORTS-1:0][lb_cfg_pkg::DATA_W-1:0] held_data;
    logic [lb_cfg_pkg::NUM_PORTS-1:0] held_valid;
    logic [lb_cfg_pkg::NUM_PORTS-1:0] stall;
    logic [lb_cfg_pkg::NUM_PORTS-1:0] loaded;
    logic [lb_cfg_pkg::NUM_CH-1:0]    ch_used;
    logic                             stall_blocked;
    logic                             group_stall;
    logic [15:0] lfsr = 16'd61;
    int value_errs = 0;
    int other_errs = 0;
    int wd_cycles = 0;

    always #10 clk = ~clk;

    load_balancer u_load_balancer (.*);

    for (genvar c = 0; c < lb_cfg_pkg::NUM_CH; c++) begin : g_mem
        tb_mem_responder u_mem (
            .clk        (clk),
            .rstn       (rstn),
            .accept_en  (mem_accept[c]),
            .lat        (mem_lat[c]),
            .m_ar_valid (m_ar_valid[c]),
            .m_ar_addr  (m_ar_addr[c]),
            .m_ar_ready (m_ar_ready[c]),
            .m_r_valid  (m_r_valid[c]),
            .m_r_data   (m_r_data[c]),
            .m_r_ready  (m_r_ready[c])
        );
    end

    // fibonacci taps 16, 14, 13, 11
    function automatic logic next_random_bit();
        logic fb;
        fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [lb_cfg_pkg::DATA_W-1:0] expected_data(
        input logic [lb_cfg_pkg::ADDR_W-1:0] addr
    );
        logic [lb_cfg_pkg::DATA_W-1:0] wide;
        wide = '0;
        wide[lb_cfg_pkg::ADDR_W-1:0] = addr;
        return wide ^ 64'hA5A5_0000_0000_0000;
    endfunction

    task automatic check_idle_outputs();
        logic [lb_cfg_pkg::NUM_PORTS-1:0] all_ones;
        logic [lb_cfg_pkg::NUM_CH-1:0]    ch_ones;
        all_ones = '1;
        ch_ones = '1;
        if (s_r_valid !== '0) begin
            $display("[ERROR] s_r_valid expected %h got %h", 4'h0, s_r_valid);
            value_errs++;
        end
        if (m_ar_valid !== '0) begin
            $display("[ERROR] m_ar_valid expected %h got %h", 4'h0, m_ar_valid);
            value_errs++;
        end
        if (s_ar_ready !== all_ones) begin
            $display("[ERROR] s_ar_ready expected %h got %h", all_ones, s_ar_ready);
            value_errs++;
        end
        // staging queues start empty so every channel takes read data
        if (m_r_ready !== ch_ones) begin
            $display("[ERROR] m_r_ready expected %h got %h", ch_ones, m_r_ready);
            value_errs++;
        end
    endtask

    // checks the values seen at this edge, then drives the next cycle
    task automatic step_cycle();
        logic [lb_cfg_pkg::PORT_W-1:0] owner;
        logic                          exp_ready;
        addr_low_t                     offset;
        for (int c = 0; c < lb_cfg_pkg::NUM_CH; c++) begin
            if (m_ar_valid[c] && m_ar_ready[c]) begin
                owner = m_ar_addr[c][lb_cfg_pkg::ADDR_W-1 -: lb_cfg_pkg::PORT_W];
                ch_used[c] = 1'b1;
                if (addr_q[owner].size() == 0) begin
                    $display("channel %0d got a read for port %0d, which has none waiting",
                             c, owner);
                    other_errs++;
                end else begin
                    if (m_ar_addr[c] !== addr_q[owner][0]) begin
                        $display("[ERROR] m_ar_addr[%0d] expected %h got %h",
                                 c, addr_q[owner][0], m_ar_addr[c]);
                        value_errs++;
                    end
                    void'(addr_q[owner].pop_front());
                end
            end
            mem_accept[c] <= next_random_bit();
            mem_lat[c] <= {next_random_bit(), next_random_bit(), next_random_bit()};
        end
        for (int p = 0; p < lb_cfg_pkg::NUM_PORTS; p++) begin
            // credit rule
            exp_ready = (outstanding[p] < lb_cfg_pkg::REQ_DEPTH);
            if (s_ar_ready[p] !== exp_ready) begin
                $display("[ERROR] s_ar_ready[%0d] expected %h got %h",
                         p, exp_ready, s_ar_ready[p]);
                value_errs++;
            end
            if (stall[p] && s_ar_valid[p] && !s_ar_ready[p]) begin
                stall_blocked = 1'b1;
            end
            if (s_ar_valid[p] && s_ar_ready[p]) begin
                addr_q[p].push_back(s_ar_addr[p]);
                exp_q[p].push_back(expected_data(s_ar_addr[p]));
                outstanding[p]++;
                sent[p]++;
            end
            if (held_valid[p] && !s_r_valid[p]) begin
                $display("port %0d dropped s_r_valid before the beat was taken", p);
                other_errs++;
            end else if (held_valid[p] && s_r_data[p] !== held_data[p]) begin
                $display("[ERROR] s_r_data[%0d] expected %h got %h", p, held_data[p], s_r_data[p]);
                value_errs++;
            end
            held_valid[p] = s_r_valid[p] & ~s_r_ready[p];
            held_data[p] = s_r_data[p];
            if (s_r_valid[p] && s_r_ready[p]) begin
                if (exp_q[p].size() == 0) begin
                    $display("port %0d returned a beat that was never requested", p);
                    other_errs++;
                end else begin
                    if (s_r_data[p] !== exp_q[p][0]) begin
                        $display("[ERROR] s_r_data[%0d] expected %h got %h",
                                 p, exp_q[p][0], s_r_data[p]);
                        value_errs++;
                    end
                    void'(exp_q[p].pop_front());
                end
                outstanding[p]--;
            end
            offset = addr_low_t'(sent[p]) << 3;
            s_ar_valid[p] <= (sent[p] < row_count[p]);
            s_ar_addr[p] <= {p[lb_cfg_pkg::PORT_W-1:0],
                             row_base[p][$bits(addr_low_t)-1:0] + offset};
            s_r_ready[p] <= stall[p] ? 1'b0 : next_random_bit();
        end
    endtask

    task automatic run_group();
        logic all_done;
        logic others_done;
        all_done = 1'b0;
        stall_blocked = 1'b0;
        ch_used = '0;
        while (!all_done) begin
            @(posedge clk);
            step_cycle();
            all_done = 1'b1;
            others_done = 1'b1;
            for (int p = 0; p < lb_cfg_pkg::NUM_PORTS; p++) begin
                if (sent[p] < row_count[p] || exp_q[p].size() != 0) begin
                    all_done = 1'b0;
                    others_done = others_done & stall[p];
                end
            end
            // stalled port drains once the others are finished
            if (others_done) begin
                stall = '0;
            end
        end
        for (int p = 0; p < lb_cfg_pkg::NUM_PORTS; p++) begin
            if (addr_q[p].size() != 0) begin
                $display("port %0d has accepted reads that never reached memory", p);
                other_errs++;
            end
        end
        if (group_stall && !stall_blocked) begin
            $display("stalled port never ran out of credit");
            other_errs++;
        end
        if (!group_stall && ch_used != '1) begin
            $display("not every channel received a read, used mask %h", ch_used);
            other_errs++;
        end
        loaded = '0;
        group_stall = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        rstn = 1'b0;
        s_ar_valid = '0;
        s_ar_addr = '0;
        s_r_ready = '0;
        mem_accept = '0;
        mem_lat = '0;
        loaded = '0;
        stall = '0;
        held_valid = '0;
        held_data = '0;
        row_base = '0;
        group_stall = 1'b0;
        for (int p = 0; p < lb_cfg_pkg::NUM_PORTS; p++) begin
            sent[p] = 0;
            row_count[p] = 0;
            outstanding[p] = 0;
        end
        @(posedge clk);
        @(posedge clk);
        check_idle_outputs();
        rstn <= 1'b1;
        @(posedge clk);
        check_idle_outputs();
        foreach (stim[r]) begin
            if (loaded[stim[r].port]) begin
                run_group();
            end
            loaded[stim[r].port] = 1'b1;
            stall[stim[r].port] = stim[r].stall;
            group_stall = group_stall | stim[r].stall;
            row_base[stim[r].port] = stim[r].base;
            row_count[stim[r].port] = int'(stim[r].count);
            sent[stim[r].port] = 0;
        end
        run_group();
        $display("errors: %0d value, %0d other", value_errs, other_errs);
        if (value_errs + other_errs == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // watchdog at 40 cycles per requested read plus margin
    initial begin
        int total;
        int limit;
        total = 0;
        foreach (stim[r]) begin
            total += int'(stim[r].count);
        end
        limit = 40 * total + 200;
        while (wd_cycles < limit) begin
            @(posedge clk);
            wd_cycles++;
        end
        $display("timeout after %0d cycles, reads still outstanding", limit);
        $display("sim failed");
        $finish;
    end

endmodule

/* all.f */
rtl/lb_cfg_pkg.sv
rtl/lb_types_pkg.sv
rtl/tag_fifo.sv
rtl/req_intake.sv
rtl/dispatch_arbiter.sv
rtl/mem_channel.sv
rtl/reorder_return.sv
rtl/load_balancer.sv
verif/tb_mem_responder.sv
verif/tb_load_balancer.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_load_balancer -f all.f -o tb_sim

out="$(./obj_dir/tb_sim)"
echo "$out"

if grep -qx "sim passed" <<< "$out"; then
    exit 0
fi
exit 1
